// File: rtl/dbus_pkg.sv
// Data bus peripheral package
// Bus widths, the one-hot region codes of the top address nibble, data memory
// geometry, cycle counter control codes and the structs that carry one bus
// cycle and one memory write between the blocks

`default_nettype none

package dbus_pkg;

    // ========================================================================
    // bus geometry
    // ========================================================================
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;    // one strobe per byte lane

    // region nibble is addr[31:28], one bit per target
    localparam int         REGION_MSB   = 31;
    localparam logic [3:0] REGION_BTN   = 4'b1000;
    localparam logic [3:0] REGION_PERF  = 4'b0100;
    localparam logic [3:0] REGION_VIDEO = 4'b0010;   // no target here, accesses dropped
    localparam logic [3:0] REGION_DMEM  = 4'b0001;

    // ========================================================================
    // targets
    // ========================================================================
    localparam int DMEM_ENTRIES = 1024;
    localparam int DMEM_ADDR_W  = 10;      // word index from addr[11:2]

    localparam int BTN_W = 4;

    localparam int         CNT_W         = 64;
    localparam logic [1:0] CTRL_CLEAR    = 2'd0;
    localparam logic [1:0] CTRL_RUN      = 2'd1;   // 2 and 3 hold the count
    localparam logic [3:0] PERF_CTRL_OFS = 4'd0;

    // one request from the bus master, we and re are single-cycle strobes
    typedef struct packed {
        logic              we;
        logic              re;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] wstrb;
    } dbus_req_t;

    // which target answers the pending read
    typedef enum logic [1:0] {
        RD_NONE,
        RD_BTN,
        RD_PERF,
        RD_DMEM
    } rd_src_t;

    // memory port, index also serves the read
    typedef struct packed {
        logic                   en;
        logic [DMEM_ADDR_W-1:0] index;
        logic [DATA_W-1:0]      wdata;
        logic [STRB_W-1:0]      wstrb;
    } mem_wr_t;

endpackage

`default_nettype wire

// File: rtl/dbus_decode.sv
// Data bus address decoder
// Splits one bus request into per-target strobes from the one-hot region
// nibble. Reads resolve buttons, then counter, then memory; writes reach
// every target whose bit is set. The read source is held in a register
// from each read strobe until the next one.

`timescale 1ns/1ps
`default_nettype none

module dbus_decode (
    input  wire                  w_clk,
    input  wire                  reset_i,
    input  wire dbus_pkg::dbus_req_t req_i,
    output dbus_pkg::mem_wr_t    mem_wr_o,
    output logic                 mem_re_o,
    output logic                 perf_we_o,
    output logic [3:0]           perf_ofs_o,
    output dbus_pkg::rd_src_t    rd_src_o
);

    logic [3:0]        region;
    logic              hit_btn;
    logic              hit_perf;
    logic              hit_dmem;
    dbus_pkg::rd_src_t rd_src_d;
    dbus_pkg::rd_src_t rd_src_q;

    assign region = req_i.addr[dbus_pkg::REGION_MSB -: 4];

    // buttons answer only when no other region bit is set
    assign hit_btn  = ((region & dbus_pkg::REGION_BTN) != 4'b0000) &&
                      ((region & (dbus_pkg::REGION_PERF | dbus_pkg::REGION_VIDEO |
                                  dbus_pkg::REGION_DMEM)) == 4'b0000);
    assign hit_perf = (region & dbus_pkg::REGION_PERF) != 4'b0000;
    assign hit_dmem = (region & dbus_pkg::REGION_DMEM) != 4'b0000;

    always_comb begin
        if (hit_btn) begin
            rd_src_d = dbus_pkg::RD_BTN;
        end else if (hit_perf) begin
            rd_src_d = dbus_pkg::RD_PERF;    // counter wins over memory
        end else if (hit_dmem) begin
            rd_src_d = dbus_pkg::RD_DMEM;
        end else begin
            rd_src_d = dbus_pkg::RD_NONE;    // video only or empty nibble
        end
    end

    // ========================================================================
    // target strobes
    // ========================================================================
    assign mem_wr_o.en    = req_i.we && hit_dmem;
    assign mem_wr_o.index = req_i.addr[dbus_pkg::DMEM_ADDR_W+1:2];   // upper bits alias
    assign mem_wr_o.wdata = req_i.wdata;
    assign mem_wr_o.wstrb = req_i.wstrb;
    assign mem_re_o       = req_i.re && (rd_src_d == dbus_pkg::RD_DMEM);

    assign perf_we_o  = req_i.we && hit_perf;
    assign perf_ofs_o = req_i.addr[3:0];

    // source of the word returned on the next cycle
    always_ff @(posedge w_clk) begin
        if (reset_i) begin
            rd_src_q <= dbus_pkg::RD_NONE;
        end else if (req_i.re) begin
            rd_src_q <= rd_src_d;
        end
    end

    assign rd_src_o = rd_src_q;

    // a bus cycle is either a read or a write
    assert property (@(posedge w_clk) disable iff (reset_i) !(req_i.we && req_i.re))
        else $error("dbus_decode: we and re high in the same cycle");

endmodule

`default_nettype wire

// File: rtl/data_mem.sv
// Data memory
// Word-addressed RAM of DMEM_ENTRIES words. Writes update only the byte
// lanes whose strobe is set. A read strobe captures the addressed word into
// the output register, which then holds until the next read.

`timescale 1ns/1ps
`default_nettype none

module data_mem (
    input  wire                        w_clk,
    input  wire dbus_pkg::mem_wr_t     wr_i,
    input  wire                        re_i,
    output logic [dbus_pkg::DATA_W-1:0] rdata_o
);

    // ========================================================================
    // storage
    // ========================================================================
    logic [dbus_pkg::DATA_W-1:0] mem_q [dbus_pkg::DMEM_ENTRIES];
    logic [dbus_pkg::DATA_W-1:0] rdata_q;

    // contents start undefined, software writes before it reads

    // ========================================================================
    // byte-lane write
    // ========================================================================
    always_ff @(posedge w_clk) begin
        if (wr_i.en) begin
            for (int b = 0; b < dbus_pkg::STRB_W; b++) begin
                if (wr_i.wstrb[b]) begin
                    mem_q[wr_i.index][b*8 +: 8] <= wr_i.wdata[b*8 +: 8];
                end
            end
        end
    end

    // ========================================================================
    // registered read
    // ========================================================================
    // index comes from the same field as the write, reads and writes
    // never share a cycle on this bus
    always_ff @(posedge w_clk) begin
        if (re_i) begin
            rdata_q <= mem_q[wr_i.index];
        end
    end

    assign rdata_o = rdata_q;

    // a store of zero bytes would mean a broken strobe encoding upstream
    assert property (@(posedge w_clk) wr_i.en |-> (wr_i.wstrb != '0))
        else $error("data_mem: write with no byte strobe at index %0d", wr_i.index);

endmodule

`default_nettype wire

// File: rtl/cycle_counter.sv
// Cycle counter
// 64-bit counter steered by a two-bit control register at offset 0 of the
// counter region. CLEAR holds it at zero, RUN adds one per clock, the other
// codes freeze it. The readout register samples one half every cycle,
// picked by address bit 2.

`timescale 1ns/1ps
`default_nettype none

module cycle_counter (
    input  wire                         w_clk,
    input  wire                         reset_i,
    input  wire                         we_i,
    input  wire  [3:0]                  ofs_i,
    input  wire  [1:0]                  wdata_i,
    output logic [dbus_pkg::DATA_W-1:0] rdata_o
);

    logic [1:0]                 ctrl_q;
    logic [dbus_pkg::CNT_W-1:0] cnt_q;
    logic [dbus_pkg::DATA_W-1:0] rdata_q;

    // ========================================================================
    // control and count
    // ========================================================================
    // the counter acts on the control value from before this edge, so a
    // new code takes effect one clock after its write
    always_ff @(posedge w_clk) begin
        if (reset_i) begin
            ctrl_q <= dbus_pkg::CTRL_CLEAR;
            cnt_q  <= '0;
        end else begin
            if (we_i && (ofs_i == dbus_pkg::PERF_CTRL_OFS)) begin
                ctrl_q <= wdata_i;
            end
            case (ctrl_q)
                dbus_pkg::CTRL_CLEAR: cnt_q <= '0;
                dbus_pkg::CTRL_RUN:   cnt_q <= cnt_q + 1;
                default:              cnt_q <= cnt_q;    // frozen
            endcase
        end
    end

    // ========================================================================
    // half-word readout
    // ========================================================================
    always_ff @(posedge w_clk) begin
        if (ofs_i[2]) begin
            rdata_q <= cnt_q[dbus_pkg::DATA_W-1:0];              // low half
        end else begin
            rdata_q <= cnt_q[dbus_pkg::CNT_W-1:dbus_pkg::DATA_W]; // high half
        end
    end

    assign rdata_o = rdata_q;

    assert property (@(posedge w_clk) disable iff (reset_i) !$isunknown(ctrl_q))
        else $error("cycle_counter: control register unknown");

endmodule

`default_nettype wire

// File: rtl/dbus_read_mux.sv
// Read data return
// Samples the push buttons and picks the word handed back to the bus
// master from the read source held by the decoder. All sources present
// data registered at the edge of the read strobe.

`timescale 1ns/1ps
`default_nettype none

module dbus_read_mux (
    input  wire                         w_clk,
    input  wire                         reset_i,
    input  wire  [dbus_pkg::BTN_W-1:0]  btn_i,
    input  wire dbus_pkg::rd_src_t      rd_src_i,
    input  wire  [dbus_pkg::DATA_W-1:0] perf_rdata_i,
    input  wire  [dbus_pkg::DATA_W-1:0] mem_rdata_i,
    output logic [dbus_pkg::DATA_W-1:0] rdata_o
);

    logic [dbus_pkg::BTN_W-1:0] btn_q;     // sampled button levels
    logic [dbus_pkg::BTN_W-1:0] btn_rd_q;  // value seen by a read at this edge

    // ========================================================================
    // button register
    // ========================================================================
    // btn_i is asynchronous, the first stage takes it into w_clk
    always_ff @(posedge w_clk) begin
        if (reset_i) begin
            btn_q <= '0;
        end else begin
            btn_q <= btn_i;
        end
    end

    // second stage lines the button value up with the counter readout
    // and the memory word, both captured at the strobe edge
    always_ff @(posedge w_clk) begin
        if (reset_i) begin
            btn_rd_q <= '0;
        end else begin
            btn_rd_q <= btn_q;
        end
    end

    // ========================================================================
    // return select
    // ========================================================================
    always_comb begin
        case (rd_src_i)
            dbus_pkg::RD_BTN: begin
                rdata_o = {{(dbus_pkg::DATA_W-dbus_pkg::BTN_W){1'b0}}, btn_rd_q};
            end
            dbus_pkg::RD_PERF: begin
                rdata_o = perf_rdata_i;
            end
            dbus_pkg::RD_DMEM: begin
                rdata_o = mem_rdata_i;
            end
            default: begin
                rdata_o = '0;     // no target behind the address
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/dbus_periph_top.sv
// Data bus peripheral block
// Decodes the CPU data bus and serves three targets: data memory, the
// cycle counter and the push-button register. Read data comes back on
// the cycle after the request.

`timescale 1ns/1ps
`default_nettype none

module dbus_periph_top (
    input  wire                         w_clk,
    input  wire                         reset_i,
    input  wire dbus_pkg::dbus_req_t    dbus_req_i,
    input  wire  [dbus_pkg::BTN_W-1:0]  btn_i,
    output logic [dbus_pkg::DATA_W-1:0] dbus_rdata_o
);

    wire dbus_pkg::mem_wr_t           mem_wr;
    wire                              mem_re;
    wire [dbus_pkg::DATA_W-1:0]       mem_rdata;
    wire                              perf_we;
    wire [3:0]                        perf_ofs;
    wire [dbus_pkg::DATA_W-1:0]       perf_rdata;
    wire dbus_pkg::rd_src_t           rd_src;

    // ========================================================================
    // decode
    // ========================================================================
    dbus_decode u_decode (
        .w_clk      (w_clk),
        .reset_i    (reset_i),
        .req_i      (dbus_req_i),
        .mem_wr_o   (mem_wr),
        .mem_re_o   (mem_re),
        .perf_we_o  (perf_we),
        .perf_ofs_o (perf_ofs),
        .rd_src_o   (rd_src)
    );

    // ========================================================================
    // targets
    // ========================================================================
    data_mem u_dmem (
        .w_clk   (w_clk),
        .wr_i    (mem_wr),
        .re_i    (mem_re),
        .rdata_o (mem_rdata)
    );

    cycle_counter u_perf (
        .w_clk   (w_clk),
        .reset_i (reset_i),
        .we_i    (perf_we),
        .ofs_i   (perf_ofs),
        .wdata_i (dbus_req_i.wdata[1:0]),   // only the control bits matter
        .rdata_o (perf_rdata)
    );

    // buttons and return path
    dbus_read_mux u_read_mux (
        .w_clk        (w_clk),
        .reset_i      (reset_i),
        .btn_i        (btn_i),
        .rd_src_i     (rd_src),
        .perf_rdata_i (perf_rdata),
        .mem_rdata_i  (mem_rdata),
        .rdata_o      (dbus_rdata_o)
    );

endmodule

`default_nettype wire

// File: tb/dbus_checker.sv
// Data bus checker
// Reference model of the data bus block. Watches the bus on every rising
// edge, predicts the word each read must return and compares it with the
// DUT output one cycle after the strobe.

`timescale 1ns/1ps
`default_nettype none

module dbus_checker (
    input  wire                         w_clk,
    input  wire                         reset_i,
    input  wire dbus_pkg::dbus_req_t    req_i,
    input  wire  [dbus_pkg::BTN_W-1:0]  btn_i,
    input  wire  [dbus_pkg::DATA_W-1:0] rdata_i,
    output int                          errors_o,
    output int                          reads_o
);

    logic [dbus_pkg::DATA_W-1:0] mem_model [dbus_pkg::DMEM_ENTRIES];
    logic [dbus_pkg::STRB_W-1:0] mem_known [dbus_pkg::DMEM_ENTRIES];  // lanes written so far
    logic [1:0]                  ctrl_model;
    logic [dbus_pkg::CNT_W-1:0]  cnt_model;
    logic [dbus_pkg::BTN_W-1:0]  btn_prev;     // btn_i at the previous edge
    logic                        pending;
    logic [dbus_pkg::ADDR_W-1:0] exp_addr;
    logic [dbus_pkg::DATA_W-1:0] exp_data;
    logic [dbus_pkg::DATA_W-1:0] exp_mask;

    // expand byte flags into a bit mask
    function automatic logic [dbus_pkg::DATA_W-1:0] lane_mask(
        input logic [dbus_pkg::STRB_W-1:0] lanes
    );
        logic [dbus_pkg::DATA_W-1:0] m;
        for (int b = 0; b < dbus_pkg::STRB_W; b++) begin
            m[b*8 +: 8] = {8{lanes[b]}};
        end
        return m;
    endfunction

    always @(posedge w_clk) begin
        logic [3:0]                       region;
        logic [dbus_pkg::DMEM_ADDR_W-1:0] idx;
        region = req_i.addr[31:28];
        idx    = req_i.addr[11:2];         // upper address bits alias
        if (reset_i) begin
            ctrl_model = dbus_pkg::CTRL_CLEAR;
            cnt_model  = '0;
            btn_prev   = '0;
            pending    = 1'b0;
            errors_o   = 0;
            reads_o    = 0;
            for (int i = 0; i < dbus_pkg::DMEM_ENTRIES; i++) begin
                mem_known[i] = '0;
            end
        end else begin
            // ================================================================
            // answer to the read strobed one edge ago
            // ================================================================
            if (pending) begin
                reads_o = reads_o + 1;
                if ((rdata_i & exp_mask) !== (exp_data & exp_mask)) begin
                    errors_o = errors_o + 1;
                    $display("ERROR at %0t ns: read of 0x%08h expected 0x%08h, got 0x%08h",
                             $time, exp_addr, exp_data & exp_mask, rdata_i);
                end
            end
            pending = 1'b0;

            if (req_i.re) begin
                pending  = 1'b1;
                exp_addr = req_i.addr;
                exp_mask = '1;
                if (region == dbus_pkg::REGION_BTN) begin
                    exp_data = {{(dbus_pkg::DATA_W-dbus_pkg::BTN_W){1'b0}}, btn_prev};
                end else if ((region & dbus_pkg::REGION_PERF) != 4'b0000) begin
                    exp_data = req_i.addr[2] ? cnt_model[31:0] : cnt_model[63:32];
                end else if ((region & dbus_pkg::REGION_DMEM) != 4'b0000) begin
                    exp_data = mem_model[idx];
                    exp_mask = lane_mask(mem_known[idx]);
                    pending  = (mem_known[idx] != '0);   // never written, skip
                end else begin
                    exp_data = '0;
                end
            end

            // writes reach every target whose region bit is set
            if (req_i.we && ((region & dbus_pkg::REGION_DMEM) != 4'b0000)) begin
                for (int b = 0; b < dbus_pkg::STRB_W; b++) begin
                    if (req_i.wstrb[b]) begin
                        mem_model[idx][b*8 +: 8] = req_i.wdata[b*8 +: 8];
                        mem_known[idx][b]        = 1'b1;
                    end
                end
            end

            // count follows the control value from before this edge
            case (ctrl_model)
                dbus_pkg::CTRL_CLEAR: cnt_model = '0;
                dbus_pkg::CTRL_RUN:   cnt_model = cnt_model + 64'd1;
                default:              cnt_model = cnt_model;
            endcase
            if (req_i.we && ((region & dbus_pkg::REGION_PERF) != 4'b0000) &&
                (req_i.addr[3:0] == dbus_pkg::PERF_CTRL_OFS)) begin
                ctrl_model = req_i.wdata[1:0];
            end

            btn_prev = btn_i;
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_dbus_periph.sv
// Data bus peripheral testbench
// Drives random bus cycles and button changes into the block on the
// falling clock edge. The checker beside the DUT predicts and compares
// every read result.

`timescale 1ns/1ps
`default_nettype none

module tb_dbus_periph;

    localparam int SEED       = 25;
    localparam int NUM_OPS    = 400;
    localparam int CLK_PERIOD = 40;

    logic                        w_clk;
    logic                        reset;
    dbus_pkg::dbus_req_t         req;
    logic [dbus_pkg::BTN_W-1:0]  btn;
    wire  [dbus_pkg::DATA_W-1:0] rdata;
    int                          errors;
    int                          reads;
    logic [31:0]                 rnd;

    initial w_clk = 1'b0;
    always #(CLK_PERIOD/2) w_clk = ~w_clk;

    dbus_periph_top uut (
        .w_clk        (w_clk),
        .reset_i      (reset),
        .dbus_req_i   (req),
        .btn_i        (btn),
        .dbus_rdata_o (rdata)
    );

    dbus_checker u_checker (
        .w_clk    (w_clk),
        .reset_i  (reset),
        .req_i    (req),
        .btn_i    (btn),
        .rdata_i  (rdata),
        .errors_o (errors),
        .reads_o  (reads)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // one bus cycle on the falling edge, buttons move now and then
    task automatic bus_cycle(input logic we, input logic re, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [3:0] wstrb);
        @(negedge w_clk);
        req.we    = we;
        req.re    = re;
        req.addr  = addr;
        req.wdata = wdata;
        req.wstrb = wstrb;
        rnd = xorshift(rnd);
        if (rnd[1:0] == 2'b00) begin
            btn = rnd[7:4];
        end
    endtask

    // ========================================================================
    // stimulus
    // ========================================================================
    initial begin
        logic [31:0] r;
        logic [31:0] d;
        logic [3:0]  strb;
        rnd   = SEED;
        reset = 1'b1;
        req   = '0;
        btn   = '0;
        repeat (2) @(posedge w_clk);
        @(negedge w_clk);
        reset = 1'b0;

        // both counter halves straight after reset
        bus_cycle(1'b0, 1'b1, 32'h4000_0000, 32'h0, 4'h0);
        bus_cycle(1'b0, 1'b1, 32'h4000_0004, 32'h0, 4'h0);

        for (int n = 0; n < NUM_OPS; n++) begin
            rnd  = xorshift(rnd);
            r    = rnd;
            rnd  = xorshift(rnd);
            d    = rnd;
            strb = (r[11:8] == 4'h0) ? 4'hF : r[11:8];
            case (r[3:0])
                4'd0, 4'd1, 4'd2, 4'd3: begin    // memory write, 16 words with aliasing
                    bus_cycle(1'b1, 1'b0, {4'h1, r[31:16], 6'd0, r[7:4], 2'b00}, d, strb);
                end
                4'd4, 4'd5, 4'd6: begin
                    bus_cycle(1'b0, 1'b1, {4'h1, r[31:16], 6'd0, r[7:4], 2'b00}, 32'h0, 4'h0);
                end
                4'd7, 4'd8: begin                // control write, mostly RUN
                    bus_cycle(1'b1, 1'b0, {4'h4, 24'h0, r[7:6], 2'b00},
                              {d[31:2], r[12] ? dbus_pkg::CTRL_RUN : d[1:0]}, 4'hF);
                end
                4'd9, 4'd10: begin
                    bus_cycle(1'b0, 1'b1, {4'h4, 25'h0, r[4], 2'b00}, 32'h0, 4'h0);
                end
                4'd11: begin
                    bus_cycle(1'b0, 1'b1, {4'h8, r[27:2], 2'b00}, 32'h0, 4'h0);
                end
                4'd12: begin                     // overlapping and empty regions
                    case (r[5:4])
                        2'd0:    bus_cycle(1'b0, 1'b1, {29'h1800_0000, r[6], 2'b00},
                                           32'h0, 4'h0);
                        2'd1:    bus_cycle(1'b0, 1'b1, {29'h0A00_0000, r[6], 2'b00},
                                           32'h0, 4'h0);
                        2'd2:    bus_cycle(1'b0, 1'b1, {4'h2, r[31:4]}, 32'h0, 4'h0);
                        default: bus_cycle(1'b0, 1'b1, {4'h0, r[31:4]}, 32'h0, 4'h0);
                    endcase
                end
                4'd13: begin                     // reaches memory and counter
                    bus_cycle(1'b1, 1'b0, {4'h5, 22'h0, r[7:4], 2'b00}, d, strb);
                end
                default: begin
                    bus_cycle(1'b0, 1'b0, 32'h0, 32'h0, 4'h0);
                end
            endcase
        end

        // let the last read come back
        bus_cycle(1'b0, 1'b0, 32'h0, 32'h0, 4'h0);
        bus_cycle(1'b0, 1'b0, 32'h0, 32'h0, 4'h0);
        @(negedge w_clk);

        $display("reads compared: %0d, errors: %0d", reads, errors);
        if (errors == 0 && reads > 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #((NUM_OPS + 100) * CLK_PERIOD);
        $display("watchdog: the test did not finish within its time limit");
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
rtl/dbus_pkg.sv
rtl/dbus_decode.sv
rtl/data_mem.sv
rtl/cycle_counter.sv
rtl/dbus_read_mux.sv
rtl/dbus_periph_top.sv
tb/dbus_checker.sv
tb/tb_dbus_periph.sv

// File: run.sh
#!/usr/bin/env bash
# Build the data bus testbench with Verilator, run it and check the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -f flist.f --top-module tb_dbus_periph \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/Vtb_dbus_periph > "$LOG" 2>&1 \
    || echo "simulation exited with a nonzero status"

cat "$LOG"

grep -qx "Result: PASSED" "$LOG" && exit 0 || exit 1
